//--- logic/bg_pixel_pipe.sv
// --------------------------------------------------------------------------
// background pixel pipeline
// fetches map entries and both tile planes from VRAM in 8 cycle slots,
// shifts the tiles out, drops the fine scroll pixels, applies BGP and
// strobes one shade per pixel to the LCD
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module bg_pixel_pipe
	import video_timing_pkg::*, video_regs_pkg::*;
#(
	parameter int SCREEN_W_P = SCREEN_W
) (
	input  logic       clk_reg,
	input  logic       reset,
	input  lcd_regs_t  regs,
	input  line_pos_t  pos,
	input  lcd_mode_t  mode,
	input  reg_data_t  vram_data,
	output logic       vram_rd,
	output vram_addr_t vram_addr,
	output logic       lcd_clkena,
	output shade_t     lcd_data
);

	localparam int    PIX_W   = $clog2(SCREEN_W_P + 1);
	localparam hcnt_t H_LATCH = hcnt_t'(OAM_LEN - 2);

	line_t            scy_r;
	line_t            bg_line;
	logic [4:0]       map_col;
	reg_data_t        tile_idx;
	reg_data_t        plane_lo;
	reg_data_t        plane_hi;
	reg_data_t        shift_lo;
	reg_data_t        shift_hi;
	logic             shift_live;
	logic [2:0]       skip_cnt;
	logic [PIX_W-1:0] pix_cnt;
	logic             fetch;
	logic [2:0]       phase;
	logic             tile_a12;
	logic [1:0]       bg_pix;
	logic             emit;

	assign fetch = (mode == MODE_XFER);
	// mode 3 starts at h_cnt 80, so the low counter bits are the slot phase
	assign phase = pos.h_cnt[2:0];

	// background row for this line
	assign bg_line = pos.ly + scy_r;

	// signed tile numbers put tiles 0..127 at 1000 and up
	assign tile_a12 = regs.tile_data_sel ? 1'b0 : ~tile_idx[7];

	// colour index leaving the shifters, high plane is bit 1
	assign bg_pix = {shift_hi[7], shift_lo[7]};

	assign emit = fetch && shift_live && (skip_cnt == 3'd0) &&
		(pix_cnt != PIX_W'(SCREEN_W_P));

	// --------------------------------------------------------------------------
	// vram access
	// --------------------------------------------------------------------------

	// phases 0-1 map, 2-3 low plane, 4-5 high plane, 6-7 shifter load
	assign vram_rd = fetch && (phase[2:1] != 2'b11);

	always_comb begin
		case (phase[2:1])
			2'b01:   vram_addr = {tile_a12, tile_idx, bg_line[2:0], 1'b0};
			2'b10:   vram_addr = {tile_a12, tile_idx, bg_line[2:0], 1'b1};
			// map at 1800 or 1c00, 32 entries per row
			default: vram_addr = {2'b11, regs.bg_map_sel, bg_line[7:3], map_col};
		endcase
	end

	// --------------------------------------------------------------------------
	// fetch and shift datapath
	// --------------------------------------------------------------------------

	always_ff @(posedge clk_reg) begin
		// scroll is frozen for the whole line
		if (pos.h_cnt == H_LATCH) begin
			scy_r   <= regs.scy;
			map_col <= regs.scx[7:3];
		end else if (fetch && (phase == 3'd7)) begin
			// next map column, wraps at 32
			map_col <= map_col + 5'd1;
		end

		// vram data arrives one cycle after the address, take it on odd phases
		if (fetch) begin
			case (phase)
				3'd1:    tile_idx <= vram_data;
				3'd3:    plane_lo <= vram_data;
				3'd5:    plane_hi <= vram_data;
				default: ;
			endcase
		end

		// tile of this slot shifts out during the next one
		if (fetch && (phase == 3'd7)) begin
			shift_lo <= plane_lo;
			shift_hi <= plane_hi;
		end else begin
			shift_lo <= {shift_lo[6:0], 1'b0};
			shift_hi <= {shift_hi[6:0], 1'b0};
		end

		// palette lookup, blank shade when the background is disabled
		if (emit)
			lcd_data <= regs.bg_ena ? regs.bgp[{bg_pix, 1'b0} +: 2] : 2'b00;
	end

	// --------------------------------------------------------------------------
	// pixel counting
	// --------------------------------------------------------------------------

	always_ff @(posedge clk_reg) begin
		if (reset) begin
			shift_live <= 1'b0;
			skip_cnt   <= '0;
			pix_cnt    <= '0;
			lcd_clkena <= 1'b0;
		end else begin
			lcd_clkena <= emit;
			if (pos.h_cnt == H_LATCH) begin
				shift_live <= 1'b0;
				// fine scroll pixels of the first tile are dropped
				skip_cnt   <= regs.scx[2:0];
				pix_cnt    <= '0;
			end else begin
				// live from the first shifter load until mode 3 ends
				shift_live <= fetch && (shift_live || (phase == 3'd7));
				if (fetch && shift_live && (skip_cnt != 3'd0))
					skip_cnt <= skip_cnt - 3'd1;
				if (emit)
					pix_cnt <= pix_cnt + 1'b1;
			end
		end
	end

endmodule

//--- logic/video_irq.sv
// --------------------------------------------------------------------------
// video interrupt unit
// registered one cycle pulses for the combined STAT interrupt and the
// vblank interrupt
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module video_irq
	import video_timing_pkg::*, video_regs_pkg::*;
(
	input  logic      clk_reg,
	input  logic      reset,
	input  lcd_regs_t regs,
	input  line_pos_t pos,
	input  lcd_mode_t mode,
	input  logic      lyc_match,
	input  logic      lyc_written,
	output logic      irq,
	output logic      vblank_irq
);

	localparam hcnt_t H_LAST    = hcnt_t'(LINE_CYCLES - 1);
	localparam line_t V_LAST_VIS = line_t'(VISIBLE_LINES - 1);

	lcd_mode_t prev_mode;
	logic      line_start;
	logic      lyc_evt;
	logic      vbl_evt;
	logic      hbl_evt;
	logic      stat_evt;

	// h_cnt sits at 0 while the lcd is off, so every event needs lcd_on
	assign line_start = regs.lcd_on && (pos.h_cnt == '0);

	// stat bit 6, compare at line start or right after a LYC write
	assign lyc_evt = regs.stat_sel[3] && lyc_match &&
		(line_start || (regs.lcd_on && lyc_written && (pos.h_cnt != '0)));

	// last cycle of the last visible line
	assign vbl_evt = regs.lcd_on && (pos.h_cnt == H_LAST) && (pos.ly == V_LAST_VIS);

	// first hblank cycle after mode 3, never true on vblank lines
	assign hbl_evt = regs.lcd_on && (mode == MODE_HBLANK) && (prev_mode == MODE_XFER);

	// stat bits 5, 4 and 3 for oam, vblank and hblank
	assign stat_evt = lyc_evt ||
		(regs.stat_sel[2] && line_start) ||
		(regs.stat_sel[1] && vbl_evt) ||
		(regs.stat_sel[0] && hbl_evt);

	always_ff @(posedge clk_reg) begin
		if (reset) begin
			prev_mode  <= MODE_HBLANK;
			irq        <= 1'b0;
			vblank_irq <= 1'b0;
		end else begin
			prev_mode  <= mode;
			irq        <= stat_evt;
			vblank_irq <= vbl_evt;
		end
	end

endmodule

//--- logic/video_regs.sv
// --------------------------------------------------------------------------
// video register block
// write decode for LCDC, STAT, SCY, SCX, LYC and BGP, the LY to LYC
// compare and the combinational CPU read mux with STAT composition
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module video_regs
	import video_timing_pkg::*, video_regs_pkg::*;
(
	input  logic      clk_reg,
	input  logic      reset,
	input  logic      cpu_sel_reg,
	input  logic      cpu_wr,
	input  reg_addr_t cpu_addr,
	input  reg_data_t cpu_di,
	input  line_pos_t pos,
	input  lcd_mode_t mode,
	output lcd_regs_t regs,
	output logic      lyc_match,
	output logic      lyc_written,
	output reg_data_t cpu_do
);

	// palette after reset maps colour 0 to white and the rest to black
	localparam reg_data_t BGP_INIT = 8'hfc;

	reg_data_t  lcdc;
	logic [3:0] stat_sel;
	reg_data_t  scy;
	reg_data_t  scx;
	reg_data_t  lyc;
	reg_data_t  bgp;
	logic       wr_en;

	assign wr_en = cpu_sel_reg && cpu_wr;

	// --------------------------------------------------------------------------
	// register writes
	// --------------------------------------------------------------------------

	always_ff @(posedge clk_reg) begin
		if (reset) begin
			// display starts switched off
			lcdc        <= '0;
			stat_sel    <= '0;
			scy         <= '0;
			scx         <= '0;
			lyc         <= '0;
			bgp         <= BGP_INIT;
			lyc_written <= 1'b0;
		end else begin
			lyc_written <= 1'b0;
			if (wr_en) begin
				case (cpu_addr)
					REG_LCDC: lcdc <= cpu_di;
					// only the interrupt enables are writable
					REG_STAT: stat_sel <= cpu_di[6:3];
					REG_SCY:  scy <= cpu_di;
					REG_SCX:  scx <= cpu_di;
					REG_LYC: begin
						lyc         <= cpu_di;
						// lets the irq unit catch a match made by the write itself
						lyc_written <= 1'b1;
					end
					REG_BGP:  bgp <= cpu_di;
					// LY is read only, the rest is unmapped
					default: ;
				endcase
			end
		end
	end

	// settings handed to the other blocks
	assign regs.lcd_on        = lcdc[7];
	assign regs.bg_map_sel    = lcdc[3];
	assign regs.tile_data_sel = lcdc[4];
	assign regs.bg_ena        = lcdc[0];
	assign regs.stat_sel      = stat_sel;
	assign regs.scy           = scy;
	assign regs.scx           = scx;
	assign regs.lyc           = lyc;
	assign regs.bgp           = bgp;

	// line compare, live on every cycle
	assign lyc_match = (pos.ly == lyc);

	// --------------------------------------------------------------------------
	// read mux
	// --------------------------------------------------------------------------

	always_comb begin
		case (cpu_addr)
			REG_LCDC: cpu_do = lcdc;
			// bit 7 always reads as one
			REG_STAT: cpu_do = {1'b1, stat_sel, lyc_match, mode};
			REG_SCY:  cpu_do = scy;
			REG_SCX:  cpu_do = scx;
			REG_LY:   cpu_do = pos.ly;
			REG_LYC:  cpu_do = lyc;
			REG_BGP:  cpu_do = bgp;
			default:  cpu_do = 8'hff;
		endcase
	end

endmodule

//--- logic/video_regs_pkg.sv
// --------------------------------------------------------------------------
// video register package
// CPU register addresses, bus widths, the pixel shade type and the
// packed set of LCD settings that the register block hands out
// --------------------------------------------------------------------------

package video_regs_pkg;

	// cpu bus and vram widths
	typedef logic [7:0]  reg_addr_t;
	typedef logic [7:0]  reg_data_t;
	typedef logic [12:0] vram_addr_t;

	// two bit monochrome shade after the palette
	typedef logic [1:0] shade_t;

	// register map, low byte of the io address
	localparam reg_addr_t REG_LCDC = 8'h40;
	localparam reg_addr_t REG_STAT = 8'h41;
	localparam reg_addr_t REG_SCY  = 8'h42;
	localparam reg_addr_t REG_SCX  = 8'h43;
	localparam reg_addr_t REG_LY   = 8'h44;
	localparam reg_addr_t REG_LYC  = 8'h45;
	localparam reg_addr_t REG_BGP  = 8'h47;

	// settings used by the timing, interrupt and pixel blocks, 40 bits
	typedef struct packed {
		// lcdc bits 7, 3, 4 and 0
		logic       lcd_on;
		logic       bg_map_sel;
		logic       tile_data_sel;
		logic       bg_ena;
		// stat interrupt enables, stat bits 6..3
		logic [3:0] stat_sel;
		reg_data_t  scy;
		reg_data_t  scx;
		reg_data_t  lyc;
		// palette, two bits per colour index
		reg_data_t  bgp;
	} lcd_regs_t;

endpackage

//--- logic/video_timing.sv
// --------------------------------------------------------------------------
// video timing generator
// horizontal and vertical raster counters, the mode 3 length from the
// fine horizontal scroll and the decoded display mode
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module video_timing
	import video_timing_pkg::*, video_regs_pkg::*;
(
	input  logic      clk_reg,
	input  logic      reset,
	input  lcd_regs_t regs,
	output line_pos_t pos,
	output lcd_mode_t mode
);

	localparam hcnt_t H_LAST    = hcnt_t'(LINE_CYCLES - 1);
	localparam line_t V_LAST    = line_t'(FRAME_LINES - 1);
	localparam line_t V_VIS     = line_t'(VISIBLE_LINES);
	// scroll is sampled two cycles before mode 3
	localparam hcnt_t H_LATCH   = hcnt_t'(OAM_LEN - 2);
	localparam hcnt_t H_XFER    = hcnt_t'(OAM_LEN);
	localparam hcnt_t H_END     = hcnt_t'(OAM_LEN + MODE3_BASE);
	localparam hcnt_t H_END_FIN = hcnt_t'(OAM_LEN + MODE3_BASE + FINE_EXTRA);

	logic [2:0] fine_r;
	hcnt_t      xfer_end;

	// --------------------------------------------------------------------------
	// raster counters
	// --------------------------------------------------------------------------

	always_ff @(posedge clk_reg) begin
		// lcd off parks the raster at the top left corner
		if (reset || !regs.lcd_on) begin
			pos    <= '0;
			fine_r <= '0;
		end else begin
			if (pos.h_cnt == H_LATCH)
				fine_r <= regs.scx[2:0];
			if (pos.h_cnt != H_LAST) begin
				pos.h_cnt <= pos.h_cnt + 1'b1;
			end else begin
				pos.h_cnt <= '0;
				// wrap to line 0 after the last vblank line
				pos.ly    <= (pos.ly == V_LAST) ? '0 : pos.ly + 1'b1;
			end
		end
	end

	// unaligned scroll costs one more fetch slot
	assign xfer_end = (fine_r != 3'd0) ? H_END_FIN : H_END;

	// --------------------------------------------------------------------------
	// mode decode
	// --------------------------------------------------------------------------

	always_comb begin
		if (!regs.lcd_on)
			mode = MODE_HBLANK;
		else if (pos.ly >= V_VIS)
			mode = MODE_VBLANK;
		else if (pos.h_cnt < H_XFER)
			mode = MODE_OAM;
		else if (pos.h_cnt < xfer_end)
			mode = MODE_XFER;
		else
			mode = MODE_HBLANK;
	end

endmodule

//--- logic/video_timing_pkg.sv
// --------------------------------------------------------------------------
// video timing package
// line and frame constants of the LCD raster, the counter types, the
// display mode encoding and the packed raster position
// --------------------------------------------------------------------------

package video_timing_pkg;

	// raster geometry in clk_reg cycles and lines
	localparam int LINE_CYCLES   = 456;
	localparam int FRAME_LINES   = 154;
	localparam int VISIBLE_LINES = 144;
	localparam int SCREEN_W      = 160;

	// mode 2 is a fixed 80 cycle window at the start of every line
	localparam int OAM_LEN = 80;

	// mode 3 length for tile aligned scroll
	localparam int MODE3_BASE = 176;
	// one more fetch slot when scx bits 2..0 are non-zero
	localparam int FINE_EXTRA = 8;

	// horizontal counter, 0..455
	typedef logic [8:0] hcnt_t;

	// line number, 0..153
	typedef logic [7:0] line_t;

	// display mode as seen in STAT bits 1..0
	typedef enum logic [1:0] {
		MODE_HBLANK = 2'd0,
		MODE_VBLANK = 2'd1,
		MODE_OAM    = 2'd2,
		MODE_XFER   = 2'd3
	} lcd_mode_t;

	// current raster position, 17 bits
	typedef struct packed {
		hcnt_t h_cnt;
		line_t ly;
	} line_pos_t;

endpackage

//--- logic/video_top.sv
// --------------------------------------------------------------------------
// video top level
// background LCD controller built from the register block, the raster
// timing generator, the interrupt unit and the background pixel pipeline
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module video_top
	import video_timing_pkg::*, video_regs_pkg::*;
#(
	parameter int SCREEN_W_P = SCREEN_W
) (
	input  logic       clk_reg,
	input  logic       reset,
	// cpu register port
	input  logic       cpu_sel_reg,
	input  logic       cpu_wr,
	input  reg_addr_t  cpu_addr,
	input  reg_data_t  cpu_di,
	output reg_data_t  cpu_do,
	// lcd side
	output logic       lcd_on,
	output logic       lcd_clkena,
	output shade_t     lcd_data,
	output logic       irq,
	output logic       vblank_irq,
	// vram side
	output lcd_mode_t  mode,
	output logic       vram_rd,
	output vram_addr_t vram_addr,
	input  reg_data_t  vram_data
);

	lcd_regs_t regs;
	line_pos_t pos;
	logic      lyc_match;
	logic      lyc_written;

	assign lcd_on = regs.lcd_on;

	// cpu visible registers
	video_regs u_regs (
		.clk_reg     (clk_reg),
		.reset       (reset),
		.cpu_sel_reg (cpu_sel_reg),
		.cpu_wr      (cpu_wr),
		.cpu_addr    (cpu_addr),
		.cpu_di      (cpu_di),
		.pos         (pos),
		.mode        (mode),
		.regs        (regs),
		.lyc_match   (lyc_match),
		.lyc_written (lyc_written),
		.cpu_do      (cpu_do)
	);

	// line and frame counters
	video_timing u_timing (
		.clk_reg (clk_reg),
		.reset   (reset),
		.regs    (regs),
		.pos     (pos),
		.mode    (mode)
	);

	// stat and vblank interrupt pulses
	video_irq u_irq (
		.clk_reg     (clk_reg),
		.reset       (reset),
		.regs        (regs),
		.pos         (pos),
		.mode        (mode),
		.lyc_match   (lyc_match),
		.lyc_written (lyc_written),
		.irq         (irq),
		.vblank_irq  (vblank_irq)
	);

	// tile fetch and pixel output
	bg_pixel_pipe #(
		.SCREEN_W_P (SCREEN_W_P)
	) u_bg_pipe (
		.clk_reg    (clk_reg),
		.reset      (reset),
		.regs       (regs),
		.pos        (pos),
		.mode       (mode),
		.vram_data  (vram_data),
		.vram_rd    (vram_rd),
		.vram_addr  (vram_addr),
		.lcd_clkena (lcd_clkena),
		.lcd_data   (lcd_data)
	);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the video testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_video \
	-Mdir obj_dir -o sim_video >build.log 2>&1 \
	&& ./obj_dir/sim_video >sim.log 2>&1 \
	|| echo "CHECKS FAILED" >>sim.log
cat build.log sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0

//--- tb/tb_video.sv
// --------------------------------------------------------------------------
// video testbench
// drives the background LCD controller with LFSR stimulus, serves VRAM
// from a registered memory model and checks registers, raster timing,
// pixels and interrupts against a reference model
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_video
	import video_timing_pkg::*, video_regs_pkg::*;
;

	localparam logic [31:0] SEED  = 32'ha55a73de;
	localparam logic [31:0] TAPS  = 32'ha3000000;
	localparam int T_LINE   = 456;
	localparam int T_LINES  = 154;
	localparam int T_VIS    = 144;
	localparam int T_PIX    = 160;
	localparam int T_OAM    = 80;
	localparam int T_XFER   = 176;
	localparam int T_FINE   = 8;
	localparam int T_FRAME  = T_LINE * T_LINES;

	logic       clk_reg;
	logic       reset;
	logic       cpu_sel_reg;
	logic       cpu_wr;
	reg_addr_t  cpu_addr;
	reg_data_t  cpu_di;
	reg_data_t  cpu_do;
	reg_data_t  vram_data = '0;
	logic       lcd_on;
	logic       lcd_clkena;
	logic       irq;
	logic       vblank_irq;
	logic       vram_rd;
	shade_t     lcd_data;
	lcd_mode_t  mode;
	vram_addr_t vram_addr;

	logic [7:0]  vram [0:8191];
	logic [31:0] lfsr;
	int          checks;
	int          errors;
	logic        hung;
	// register values the model works from
	reg_data_t   cfg_lcdc;
	reg_data_t   cfg_scx;
	reg_data_t   cfg_scy;
	reg_data_t   cfg_bgp;

	video_top #(
		.SCREEN_W_P (SCREEN_W)
	) dut (
		.clk_reg     (clk_reg),
		.reset       (reset),
		.cpu_sel_reg (cpu_sel_reg),
		.cpu_wr      (cpu_wr),
		.cpu_addr    (cpu_addr),
		.cpu_di      (cpu_di),
		.cpu_do      (cpu_do),
		.lcd_on      (lcd_on),
		.lcd_clkena  (lcd_clkena),
		.lcd_data    (lcd_data),
		.irq         (irq),
		.vblank_irq  (vblank_irq),
		.mode        (mode),
		.vram_rd     (vram_rd),
		.vram_addr   (vram_addr),
		.vram_data   (vram_data)
	);

	initial begin
		clk_reg = 1'b0;
		forever #5 clk_reg = ~clk_reg;
	end

	// vram with one cycle read latency
	always @(posedge clk_reg)
		vram_data <= vram[vram_addr];

	// --------------------------------------------------------------------------
	// helpers
	// --------------------------------------------------------------------------

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ TAPS) : (lfsr >> 1);
		end
		return v;
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("ERR t=%0t %s expected %0h actual %0h", $time, name, exp, act);
		end
	endtask

	task automatic report(input string name, input int e0, input int c0);
		$display("test %s done: %0d checks, %0d errors", name, checks - c0, errors - e0);
	endtask

	task automatic reg_write(input reg_addr_t a, input reg_data_t d);
		@(negedge clk_reg);
		cpu_sel_reg = 1'b1;
		cpu_wr      = 1'b1;
		cpu_addr    = a;
		cpu_di      = d;
		@(negedge clk_reg);
		cpu_sel_reg = 1'b0;
		cpu_wr      = 1'b0;
	endtask

	task automatic reg_read(input reg_addr_t a, output reg_data_t d);
		@(negedge clk_reg);
		cpu_sel_reg = 1'b1;
		cpu_addr    = a;
		@(negedge clk_reg);
		d           = cpu_do;
		cpu_sel_reg = 1'b0;
	endtask

	task automatic wait_mode(input lcd_mode_t m, input int limit);
		int n;
		n = 0;
		while ((mode != m) && (n < limit) && !hung) begin
			@(negedge clk_reg);
			n++;
		end
		if (!hung && (mode != m)) begin
			hung = 1'b1;
			errors++;
			$display("timeout: mode %0d never showed up within %0d cycles", m, limit);
		end
	endtask

	// lands on the first vblank cycle so that writes stay in vblank
	task automatic wait_vblank_start();
		wait_mode(MODE_OAM, 2 * T_FRAME);
		wait_mode(MODE_VBLANK, 2 * T_FRAME);
	endtask

	// mode by the raster rules, c is the cycle within the line
	function automatic lcd_mode_t expect_mode(input int ly, input int c);
		int xfer_end;
		xfer_end = T_OAM + T_XFER + ((cfg_scx[2:0] != 3'd0) ? T_FINE : 0);
		if (ly >= T_VIS)
			return MODE_VBLANK;
		else if (c < T_OAM)
			return MODE_OAM;
		else if (c < xfer_end)
			return MODE_XFER;
		return MODE_HBLANK;
	endfunction

	// reference pixel: scrolled map lookup, tile data, then palette
	function automatic shade_t model_pixel(input int y, input int i);
		int row;
		int col;
		int map_a;
		int tile;
		int data_a;
		int bit_n;
		int ci;
		row   = (y + int'(cfg_scy)) % 256;
		col   = (int'(cfg_scx) + i) % 256;
		map_a = 'h1800 + (cfg_lcdc[3] ? 'h400 : 0) + (row / 8) * 32 + col / 8;
		tile  = int'(vram[map_a]);
		// unsigned tiles from 0000, signed ones around 1000
		if (cfg_lcdc[4])
			data_a = tile * 16;
		else
			data_a = (tile < 128) ? 'h1000 + tile * 16 : tile * 16;
		data_a = data_a + (row % 8) * 2;
		bit_n  = 7 - col % 8;
		ci     = 2 * int'(vram[data_a + 1][bit_n]) + int'(vram[data_a][bit_n]);
		if (!cfg_lcdc[0])
			return 2'd0;
		return shade_t'(cfg_bgp >> (2 * ci));
	endfunction

	// one frame of pixels, starting on the first cycle of line 0
	task automatic capture_frame();
		int line;
		int pix;
		int n;
		lcd_mode_t last;
		line = 0;
		pix  = 0;
		n    = 0;
		last = mode;
		while ((mode != MODE_VBLANK) && (n < T_FRAME) && !hung) begin
			if ((mode == MODE_OAM) && (last != MODE_OAM) && (n > 0)) begin
				check("strobes_per_line", T_PIX, pix);
				line++;
				pix = 0;
			end
			// mode 3 length follows the fine scroll of this setup
			check("mode", expect_mode(n / T_LINE, n % T_LINE), mode);
			if (lcd_clkena) begin
				check("lcd_data", model_pixel(line, pix), lcd_data);
				pix++;
			end
			last = mode;
			@(negedge clk_reg);
			n++;
		end
		if (!hung && (mode != MODE_VBLANK)) begin
			hung = 1'b1;
			errors++;
			$display("timeout: frame never reached vblank while capturing pixels");
		end
		check("strobes_per_line", T_PIX, pix);
		check("visible_lines", T_VIS, line + 1);
	endtask

	// counts pulses over exactly one frame from the current cycle
	task automatic count_pulses(output int n_irq, output int n_vbl, output int n_act);
		n_irq = 0;
		n_vbl = 0;
		n_act = 0;
		for (int n = 0; n < T_FRAME; n++) begin
			if (irq)
				n_irq++;
			if (vblank_irq)
				n_vbl++;
			if (lcd_clkena || vram_rd)
				n_act++;
			@(negedge clk_reg);
		end
	endtask

	// --------------------------------------------------------------------------
	// test sequence
	// --------------------------------------------------------------------------

	initial begin
		int e0;
		int c0;
		int ly_prev;
		int ly_now;
		int c;
		int changes;
		int n_irq;
		int n_vbl;
		int n_act;
		logic [2:0] sel;
		reg_data_t d;
		reg_data_t r;
		reg_data_t a;
		reg_data_t lyc_m;

		reset       = 1'b1;
		cpu_sel_reg = 1'b0;
		cpu_wr      = 1'b0;
		cpu_addr    = '0;
		cpu_di      = '0;
		checks      = 0;
		errors      = 0;
		hung        = 1'b0;
		lfsr        = SEED;
		for (int k = 0; k < 8192; k++) begin
			d       = reg_data_t'(rand_bits(8));
			vram[k] = d;
		end
		repeat (8) @(negedge clk_reg);
		reset = 1'b0;

		// register access with the display off
		e0    = errors;
		c0    = checks;
		lyc_m = '0;
		for (int it = 0; it < 40; it++) begin
			sel = 3'(rand_bits(3));
			d   = reg_data_t'(rand_bits(8));
			case (sel)
				3'd0: begin
					d[7] = 1'b0;
					reg_write(REG_LCDC, d);
					reg_read(REG_LCDC, r);
					check("lcdc", d, r);
				end
				3'd1: begin
					reg_write(REG_SCY, d);
					reg_read(REG_SCY, r);
					check("scy", d, r);
				end
				3'd2: begin
					reg_write(REG_SCX, d);
					reg_read(REG_SCX, r);
					check("scx", d, r);
				end
				3'd3: begin
					lyc_m = d;
					reg_write(REG_LYC, d);
					reg_read(REG_LYC, r);
					check("lyc", d, r);
				end
				3'd4: begin
					reg_write(REG_BGP, d);
					reg_read(REG_BGP, r);
					check("bgp", d, r);
				end
				3'd5: begin
					reg_write(REG_STAT, d);
					reg_read(REG_STAT, r);
					// ly is 0 and mode is 0 while off
					check("stat", {1'b1, d[6:3], (lyc_m == 8'd0), 2'b00}, r);
				end
				3'd6: begin
					reg_write(REG_LY, d);
					reg_read(REG_LY, r);
					check("ly", 8'd0, r);
				end
				default: begin
					a = reg_data_t'(rand_bits(8));
					if ((a >= 8'h40) && (a <= 8'h47) && (a != 8'h46))
						a = a ^ 8'h80;
					reg_read(a, r);
					check("unmapped", 8'hff, r);
				end
			endcase
		end
		report("register_access", e0, c0);

		// frame timing with tile aligned scroll
		e0       = errors;
		c0       = checks;
		cfg_scx  = '0;
		cfg_scy  = '0;
		cfg_bgp  = 8'he4;
		cfg_lcdc = 8'h91;
		reg_write(REG_STAT, 8'h00);
		reg_write(REG_SCX, cfg_scx);
		reg_write(REG_SCY, cfg_scy);
		reg_write(REG_BGP, cfg_bgp);
		reg_write(REG_LCDC, cfg_lcdc);
		check("lcd_on", 1, lcd_on);
		cpu_addr = REG_LY;
		// LY is sampled from the next falling edge on
		@(negedge clk_reg);
		ly_prev  = int'(cpu_do);
		c        = -1;
		changes  = 0;
		for (int n = 0; (n < 160 * T_LINE) && (changes < T_LINES + 2); n++) begin
			@(negedge clk_reg);
			ly_now = int'(cpu_do);
			if (ly_now != ly_prev) begin
				if (changes > 0)
					check("line_cycles", T_LINE, c + 1);
				check("ly", (ly_prev + 1) % T_LINES, ly_now);
				changes++;
				c       = 0;
				ly_prev = ly_now;
			end else if (c >= 0) begin
				c++;
			end
			if (c >= 0)
				check("mode", expect_mode(ly_now, c), mode);
		end
		if (changes < T_LINES + 2) begin
			hung = 1'b1;
			errors++;
			$display("timeout: LY stopped advancing after %0d line changes", changes);
		end
		report("frame_timing", e0, c0);

		// pixels over random scroll, palette and tile setup
		e0 = errors;
		c0 = checks;
		for (int cfg = 0; (cfg < 4) && !hung; cfg++) begin
			wait_vblank_start();
			cfg_scx  = reg_data_t'(rand_bits(8));
			cfg_scy  = reg_data_t'(rand_bits(8));
			cfg_bgp  = reg_data_t'(rand_bits(8));
			cfg_lcdc = {1'b1, 2'b00, 1'(rand_bits(1)), 1'(rand_bits(1)), 2'b00,
				(rand_bits(2) != 0)};
			reg_write(REG_SCX, cfg_scx);
			reg_write(REG_SCY, cfg_scy);
			reg_write(REG_BGP, cfg_bgp);
			reg_write(REG_LCDC, cfg_lcdc);
			wait_mode(MODE_OAM, 2 * T_FRAME);
			if (!hung)
				capture_frame();
		end
		report("pixels", e0, c0);

		// hblank source, then the lyc source
		e0 = errors;
		c0 = checks;
		wait_vblank_start();
		reg_write(REG_STAT, 8'h08);
		wait_mode(MODE_OAM, 2 * T_FRAME);
		count_pulses(n_irq, n_vbl, n_act);
		check("irq_hblank_count", T_VIS, n_irq);
		check("vblank_irq_count", 1, n_vbl);
		wait_vblank_start();
		reg_write(REG_STAT, 8'h40);
		d = reg_data_t'(rand_bits(8) % T_LINES);
		reg_write(REG_LYC, d);
		wait_mode(MODE_OAM, 2 * T_FRAME);
		count_pulses(n_irq, n_vbl, n_act);
		check("irq_lyc_count", 1, n_irq);
		check("vblank_irq_count", 1, n_vbl);
		report("interrupts", e0, c0);

		// display off
		e0 = errors;
		c0 = checks;
		wait_vblank_start();
		reg_write(REG_STAT, 8'h00);
		reg_write(REG_LCDC, 8'h00);
		check("lcd_on", 0, lcd_on);
		reg_read(REG_LY, r);
		check("ly", 8'd0, r);
		check("mode", MODE_HBLANK, mode);
		count_pulses(n_irq, n_vbl, n_act);
		check("activity_while_off", 0, n_act);
		check("vblank_irq_count", 0, n_vbl);
		reg_read(REG_LY, r);
		check("ly", 8'd0, r);
		report("lcd_off", e0, c0);

		$display("summary: %0d checks, %0d errors", checks, errors);
		if ((errors == 0) && !hung)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- tb/video_checker.sv
// --------------------------------------------------------------------------
// video checker
// concurrent assertions on the video top level ports, bound into the DUT
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module video_checker
	import video_timing_pkg::*;
(
	input logic      clk_reg,
	input logic      reset,
	input logic      lcd_on,
	input logic      lcd_clkena,
	input logic      irq,
	input logic      vblank_irq,
	input logic      vram_rd,
	input lcd_mode_t mode,
	input line_t     ly
);

	// pixel strobes only while the line is being transferred
	clkena_in_xfer: assert property (@(posedge clk_reg) disable iff (reset)
		lcd_clkena |-> (mode == MODE_XFER))
		else $error("lcd_clkena outside mode 3");

	// mode 3 is entered only from mode 2 of a visible line
	xfer_after_oam: assert property (@(posedge clk_reg) disable iff (reset)
		((mode == MODE_XFER) && ($past(mode) != MODE_XFER)) |->
			(($past(mode) == MODE_OAM) && (ly < line_t'(VISIBLE_LINES))))
		else $error("mode 3 entered outside mode 2 of a visible line");

	// vblank interrupt is a single cycle pulse
	vblank_single: assert property (@(posedge clk_reg) disable iff (reset)
		vblank_irq |=> !vblank_irq)
		else $error("vblank_irq longer than one cycle");

	// display off parks the mode, stops vram traffic and silences the
	// registered strobes and interrupts from the next cycle on
	off_is_idle: assert property (@(posedge clk_reg) disable iff (reset)
		!lcd_on |=> (!lcd_clkena && !irq && !vblank_irq &&
			(lcd_on || ((mode == MODE_HBLANK) && !vram_rd))))
		else $error("activity while the lcd is off");

endmodule

// ly is taken from the raster position inside the top level
bind video_top video_checker u_checker (
	.clk_reg    (clk_reg),
	.reset      (reset),
	.lcd_on     (lcd_on),
	.lcd_clkena (lcd_clkena),
	.irq        (irq),
	.vblank_irq (vblank_irq),
	.vram_rd    (vram_rd),
	.mode       (mode),
	.ly         (pos.ly)
);

//--- vlog.f
logic/video_timing_pkg.sv
logic/video_regs_pkg.sv
logic/video_regs.sv
logic/video_timing.sv
logic/video_irq.sv
logic/bg_pixel_pipe.sv
logic/video_top.sv
tb/video_checker.sv
tb/tb_video.sv
